/* dual_issue_rf.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/rf_pkg.sv
hdl/clear_counter.sv
hdl/clear_sequencer.sv
hdl/regfile_3r2w.sv
hdl/issue_decode.sv
hdl/exec_writeback.sv
hdl/dual_issue_rf.sv
sim/tb_dual_issue_rf.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f dual_issue_rf.f --top-module tb_dual_issue_rf \
    -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/Vtb_dual_issue_rf >> sim.log 2>&1 \
    || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

/* sim/tb_dual_issue_rf.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module tb_dual_issue_rf;

    localparam int W       = `RF_WIDTH;
    localparam int AW      = `RF_ADDR_W;
    localparam int TIMEOUT = 40;

    // what the checker expects in the cycle after a pair is offered.
    typedef struct packed {
        int           due;
        logic         v0;
        logic [W-1:0] r0;
        logic         v1;
        logic [W-1:0] r1;
    } expect_t;

    logic           clock = 1'b0;
    logic           arst_n;
    isa_pkg::inst_u inst_0;
    isa_pkg::inst_u inst_1;
    logic           inst_valid;
    logic           flush;
    logic           ready;
    logic [W-1:0]   result_0;
    logic [W-1:0]   result_1;
    logic           result_valid_0;
    logic           result_valid_1;

    logic [W-1:0]   model [`RF_DEPTH];
    expect_t        pending [$];
    logic [31:0]    rng_state = 32'd16;
    int             cycle = 0;

    dual_issue_rf dut0 (
        .clock(clock), .arst_n(arst_n), .inst_0(inst_0), .inst_1(inst_1),
        .inst_valid(inst_valid), .flush(flush), .ready(ready),
        .result_0(result_0), .result_1(result_1),
        .result_valid_0(result_valid_0), .result_valid_1(result_valid_1)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // ========================================
    // failure reporting and compares.
    // ========================================

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input logic [W-1:0] got,
                                input logic [W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ========================================
    // random numbers and instruction words.
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic reads_two_regs(input isa_pkg::opcode_e op);
        return (op == isa_pkg::add) || (op == isa_pkg::sub) ||
               (op == isa_pkg::and_op) || (op == isa_pkg::xor_op);
    endfunction

    function automatic isa_pkg::inst_u make_rr(input isa_pkg::opcode_e op,
                                               input logic [AW-1:0] rd,
                                               input logic [AW-1:0] rs1,
                                               input logic [AW-1:0] rs2);
        isa_pkg::inst_u w;
        w.rr.op  = op;
        w.rr.rd  = rd;
        w.rr.rs1 = rs1;
        w.rr.rs2 = rs2;
        w.rr.pad = '0;
        return w;
    endfunction

    function automatic isa_pkg::inst_u make_ri(input isa_pkg::opcode_e op,
                                               input logic [AW-1:0] rd,
                                               input logic [AW-1:0] rs1,
                                               input isa_pkg::imm_t imm);
        isa_pkg::inst_u w;
        w.ri.op  = op;
        w.ri.rd  = rd;
        w.ri.rs1 = rs1;
        w.ri.imm = imm;
        return w;
    endfunction

    function automatic isa_pkg::inst_u rand_slot0();
        logic [31:0]      r;
        isa_pkg::opcode_e op;
        r  = next_rand();
        op = isa_pkg::opcode_e'({1'b0, r[2:0]});
        if (reads_two_regs(op)) begin
            return make_rr(op, r[6:4], r[9:7], r[12:10]);
        end
        return make_ri(op, r[6:4], r[9:7], r[18:13]);
    endfunction

    // slot 1 only takes the immediate format.
    function automatic isa_pkg::inst_u rand_slot1();
        logic [31:0]      r;
        isa_pkg::opcode_e op;
        r = next_rand();
        case (r[1:0])
            2'd0:    op = isa_pkg::nop;
            2'd1:    op = isa_pkg::addi;
            2'd2:    op = isa_pkg::setlo;
            default: op = isa_pkg::sethi;
        endcase
        return make_ri(op, r[6:4], r[9:7], r[18:13]);
    endfunction

    // ========================================
    // reference model.
    // ========================================

    function automatic void clear_model();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            model[i] = '0;
        end
    endfunction

    function automatic logic [W-1:0] op_value(input isa_pkg::opcode_e op, input logic [W-1:0] a,
                                              input logic [W-1:0] b, input isa_pkg::imm_t imm);
        logic [W-1:0] simm;
        logic [W-1:0] uimm;
        simm = W'($signed(imm));
        uimm = W'(imm);
        case (op)
            isa_pkg::add:    return a + b;
            isa_pkg::sub:    return a - b;
            isa_pkg::and_op: return a & b;
            isa_pkg::xor_op: return a ^ b;
            isa_pkg::addi:   return a + simm;
            isa_pkg::setlo:  return uimm;
            isa_pkg::sethi:  return uimm << `RF_LANE_W;
            default:         return '0;
        endcase
    endfunction

    function automatic rf_pkg::lane_mask_t lanes_written(input isa_pkg::opcode_e op);
        if (op == isa_pkg::nop) begin
            return 2'b00;
        end else if (op == isa_pkg::setlo) begin
            return 2'b01;
        end else if (op == isa_pkg::sethi) begin
            return 2'b10;
        end
        return 2'b11;
    endfunction

    function automatic void write_lanes(input logic [AW-1:0] rd, input logic [W-1:0] value,
                                        input rf_pkg::lane_mask_t mask);
        for (int l = 0; l < `RF_LANES; l++) begin
            if (mask[l]) begin
                model[rd][l*`RF_LANE_W +: `RF_LANE_W] = value[l*`RF_LANE_W +: `RF_LANE_W];
            end
        end
    endfunction

    function automatic void ref_exec(input isa_pkg::inst_u w0, input isa_pkg::inst_u w1,
                                     output logic v0, output logic [W-1:0] r0,
                                     output logic v1, output logic [W-1:0] r1);
        isa_pkg::opcode_e op0;
        isa_pkg::opcode_e op1;
        logic [W-1:0]     a0;
        logic [W-1:0]     b0;
        logic [AW-1:0]    d0;
        op0 = w0.rr.op;
        op1 = w1.ri.op;
        // both slots see the registers as they were before the pair.
        if (reads_two_regs(op0)) begin
            a0 = model[w0.rr.rs1];
            b0 = model[w0.rr.rs2];
            d0 = w0.rr.rd;
        end else begin
            a0 = model[w0.ri.rs1];
            b0 = '0;
            d0 = w0.ri.rd;
        end
        r0 = op_value(op0, a0, b0, w0.ri.imm);
        r1 = op_value(op1, model[w1.ri.rs1], '0, w1.ri.imm);
        v0 = (op0 != isa_pkg::nop);
        v1 = (op1 != isa_pkg::nop);
        write_lanes(d0, r0, lanes_written(op0));
        // slot 1 goes last and wins on a shared lane.
        write_lanes(w1.ri.rd, r1, lanes_written(op1));
    endfunction

    // ========================================
    // stimulus.
    // ========================================

    task automatic drive_pair(input isa_pkg::inst_u w0, input isa_pkg::inst_u w1);
        expect_t e;
        inst_0     = w0;
        inst_1     = w1;
        inst_valid = 1'b1;
        flush      = 1'b0;
        e          = '0;
        e.due      = cycle + 1;
        // a pair offered while ready is low is dropped.
        if (ready) begin
            ref_exec(w0, w1, e.v0, e.r0, e.v1, e.r1);
        end
        pending.push_back(e);
    endtask

    task automatic issue_pair(input isa_pkg::inst_u w0, input isa_pkg::inst_u w1);
        @(negedge clock);
        drive_pair(w0, w1);
    endtask

    task automatic wait_ready(input logic drop_pairs, output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            @(negedge clock);
            inst_valid = 1'b0;
            flush      = 1'b0;
            if (ready) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (drop_pairs) begin
                    drive_pair(rand_slot0(), rand_slot1());
                end
                if (cycles > TIMEOUT) begin
                    fail_run($sformatf("ready did not rise within %0d cycles", TIMEOUT));
                end
            end
        end
    endtask

    task automatic read_all_back();
        for (int r = 0; r < `RF_DEPTH / 2; r++) begin
            issue_pair(make_ri(isa_pkg::addi, AW'(r), AW'(r), '0),
                       make_ri(isa_pkg::addi, AW'(r + 4), AW'(r + 4), '0));
        end
    endtask

    task automatic drain_checks();
        int n;
        n = 0;
        while (pending.size() > 0) begin
            @(negedge clock);
            inst_valid = 1'b0;
            n++;
            if (n > TIMEOUT) begin
                fail_run("expected results were still pending at the end of the run");
            end
        end
    endtask

    // results are compared mid-cycle, one cycle after the pair was offered.
    always @(negedge clock) begin : compare_results
        expect_t e;
        if ((pending.size() > 0) && (pending[0].due == cycle)) begin
            e = pending.pop_front();
            check_valid("result_valid_0", result_valid_0, e.v0);
            check_valid("result_valid_1", result_valid_1, e.v1);
            if (e.v0) begin
                check_result("result_0", result_0, e.r0);
            end
            if (e.v1) begin
                check_result("result_1", result_1, e.r1);
            end
        end
    end

    initial begin
        int clr_cycles;
        arst_n     = 1'b0;
        inst_0     = '0;
        inst_1     = '0;
        inst_valid = 1'b0;
        flush      = 1'b0;
        clear_model();
        repeat (5) @(negedge clock);
        check_valid("ready", ready, 1'b0);
        check_valid("result_valid_0", result_valid_0, 1'b0);
        check_valid("result_valid_1", result_valid_1, 1'b0);
        arst_n = 1'b1;
        wait_ready(1'b0, clr_cycles);
        read_all_back();

        // fill every register through both lanes, then mix freely.
        for (int r = 0; r < `RF_DEPTH; r++) begin
            issue_pair(make_ri(isa_pkg::setlo, AW'(r), '0, isa_pkg::imm_t'(next_rand())),
                       make_ri(isa_pkg::sethi, AW'(r), '0, isa_pkg::imm_t'(next_rand())));
        end
        for (int i = 0; i < 80; i++) begin
            issue_pair(rand_slot0(), rand_slot1());
        end
        read_all_back();

        // lane writes merge across consecutive pairs.
        issue_pair(make_ri(isa_pkg::setlo, 3'd6, '0, 6'h2b),
                   make_ri(isa_pkg::nop, '0, '0, '0));
        issue_pair(make_ri(isa_pkg::sethi, 3'd6, '0, 6'h15),
                   make_ri(isa_pkg::nop, '0, '0, '0));
        issue_pair(make_ri(isa_pkg::addi, 3'd7, 3'd6, '0),
                   make_ri(isa_pkg::addi, 3'd0, 3'd6, 6'h3f));

        // same-pair priority and old-value reads.
        issue_pair(make_ri(isa_pkg::addi, 3'd3, 3'd1, 6'h05),
                   make_ri(isa_pkg::addi, 3'd3, 3'd2, 6'h09));
        issue_pair(make_ri(isa_pkg::setlo, 3'd2, '0, 6'h11),
                   make_ri(isa_pkg::addi, 3'd5, 3'd2, '0));
        issue_pair(make_ri(isa_pkg::addi, 3'd4, 3'd3, 6'h01),
                   make_ri(isa_pkg::setlo, 3'd4, '0, 6'h3c));
        read_all_back();

        // flush in run, then every pair during clearing is dropped.
        @(negedge clock);
        inst_valid = 1'b0;
        flush      = 1'b1;
        clear_model();
        wait_ready(1'b1, clr_cycles);
        if (clr_cycles != `RF_DEPTH / 2) begin
            fail_run($sformatf("clear after flush took %0d cycles instead of %0d",
                               clr_cycles, `RF_DEPTH / 2));
        end
        read_all_back();
        drain_checks();

        $display("Regression passed");
        $finish;
    end

endmodule

/* hdl/dual_issue_rf.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module dual_issue_rf (
    input  logic                 clock,
    input  logic                 arst_n,
    input  isa_pkg::inst_u       inst_0,
    input  isa_pkg::inst_u       inst_1,
    input  logic                 inst_valid,
    input  logic                 flush,
    output logic                 ready,
    output logic [`RF_WIDTH-1:0] result_0,
    output logic [`RF_WIDTH-1:0] result_1,
    output logic                 result_valid_0,
    output logic                 result_valid_1
);

    logic [`RF_ADDR_W-1:0] rd_addr_0;
    logic [`RF_ADDR_W-1:0] rd_addr_1;
    logic [`RF_ADDR_W-1:0] rd_addr_2;
    logic                  rd_enable_0;
    logic                  rd_enable_1;
    logic                  rd_enable_2;
    logic [`RF_WIDTH-1:0]  rd_dout_0;
    logic [`RF_WIDTH-1:0]  rd_dout_1;
    logic [`RF_WIDTH-1:0]  rd_dout_2;
    logic [`RF_ADDR_W-1:0] wr_addr_0;
    logic [`RF_ADDR_W-1:0] wr_addr_1;
    rf_pkg::lane_mask_t    wr_enable_0;
    rf_pkg::lane_mask_t    wr_enable_1;
    logic [`RF_WIDTH-1:0]  wr_din_0;
    logic [`RF_WIDTH-1:0]  wr_din_1;
    isa_pkg::opcode_e      ex_op_0;
    isa_pkg::opcode_e      ex_op_1;
    logic [`RF_ADDR_W-1:0] ex_rd_0;
    logic [`RF_ADDR_W-1:0] ex_rd_1;
    isa_pkg::imm_t         ex_imm_0;
    isa_pkg::imm_t         ex_imm_1;
    logic                  ex_valid_0;
    logic                  ex_valid_1;
    logic                  clearing;
    logic                  start;
    logic                  last_pair;
    logic [`RF_ADDR_W-1:0] clear_addr;

    issue_decode u_decode (
        .clock(clock), .arst_n(arst_n), .inst_0(inst_0), .inst_1(inst_1),
        .inst_valid(inst_valid), .ready(ready),
        .rd_addr_0(rd_addr_0), .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .rd_enable_0(rd_enable_0), .rd_enable_1(rd_enable_1), .rd_enable_2(rd_enable_2),
        .ex_op_0(ex_op_0), .ex_op_1(ex_op_1), .ex_rd_0(ex_rd_0), .ex_rd_1(ex_rd_1),
        .ex_imm_0(ex_imm_0), .ex_imm_1(ex_imm_1),
        .ex_valid_0(ex_valid_0), .ex_valid_1(ex_valid_1)
    );

    regfile_3r2w u_regfile (
        .clock(clock),
        .rd_addr_0(rd_addr_0), .rd_enable_0(rd_enable_0), .rd_dout_0(rd_dout_0),
        .rd_addr_1(rd_addr_1), .rd_enable_1(rd_enable_1), .rd_dout_1(rd_dout_1),
        .rd_addr_2(rd_addr_2), .rd_enable_2(rd_enable_2), .rd_dout_2(rd_dout_2),
        .wr_addr_0(wr_addr_0), .wr_enable_0(wr_enable_0), .wr_din_0(wr_din_0),
        .wr_addr_1(wr_addr_1), .wr_enable_1(wr_enable_1), .wr_din_1(wr_din_1)
    );

    exec_writeback u_exec (
        .clock(clock), .arst_n(arst_n),
        .ex_op_0(ex_op_0), .ex_op_1(ex_op_1), .ex_rd_0(ex_rd_0), .ex_rd_1(ex_rd_1),
        .ex_imm_0(ex_imm_0), .ex_imm_1(ex_imm_1),
        .ex_valid_0(ex_valid_0), .ex_valid_1(ex_valid_1),
        .rd_dout_0(rd_dout_0), .rd_dout_1(rd_dout_1), .rd_dout_2(rd_dout_2),
        .clearing(clearing), .clear_addr(clear_addr),
        .wr_addr_0(wr_addr_0), .wr_addr_1(wr_addr_1),
        .wr_enable_0(wr_enable_0), .wr_enable_1(wr_enable_1),
        .wr_din_0(wr_din_0), .wr_din_1(wr_din_1),
        .result_0(result_0), .result_1(result_1),
        .result_valid_0(result_valid_0), .result_valid_1(result_valid_1)
    );

    // the counter advances on every clearing cycle.
    clear_counter u_counter (
        .clock(clock), .arst_n(arst_n), .start(start), .step(clearing),
        .clear_addr(clear_addr), .last_pair(last_pair)
    );

    clear_sequencer u_sequencer (
        .clock(clock), .arst_n(arst_n), .flush(flush), .last_pair(last_pair),
        .clearing(clearing), .ready(ready), .start(start)
    );

endmodule

/* hdl/exec_writeback.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module exec_writeback (
    input  logic                  clock,
    input  logic                  arst_n,
    input  isa_pkg::opcode_e      ex_op_0,
    input  isa_pkg::opcode_e      ex_op_1,
    input  logic [`RF_ADDR_W-1:0] ex_rd_0,
    input  logic [`RF_ADDR_W-1:0] ex_rd_1,
    input  isa_pkg::imm_t         ex_imm_0,
    input  isa_pkg::imm_t         ex_imm_1,
    input  logic                  ex_valid_0,
    input  logic                  ex_valid_1,
    input  logic [`RF_WIDTH-1:0]  rd_dout_0,
    input  logic [`RF_WIDTH-1:0]  rd_dout_1,
    input  logic [`RF_WIDTH-1:0]  rd_dout_2,
    input  logic                  clearing,
    input  logic [`RF_ADDR_W-1:0] clear_addr,
    output logic [`RF_ADDR_W-1:0] wr_addr_0,
    output logic [`RF_ADDR_W-1:0] wr_addr_1,
    output rf_pkg::lane_mask_t    wr_enable_0,
    output rf_pkg::lane_mask_t    wr_enable_1,
    output logic [`RF_WIDTH-1:0]  wr_din_0,
    output logic [`RF_WIDTH-1:0]  wr_din_1,
    output logic [`RF_WIDTH-1:0]  result_0,
    output logic [`RF_WIDTH-1:0]  result_1,
    output logic                  result_valid_0,
    output logic                  result_valid_1
);

    localparam int W     = `RF_WIDTH;
    localparam int LW    = `RF_LANE_W;
    localparam int IMM_W = $bits(isa_pkg::imm_t);

    // setlo and sethi leave the other lane at zero.
    function automatic logic [W-1:0] alu(input isa_pkg::opcode_e op, input logic [W-1:0] a,
                                         input logic [W-1:0] b, input isa_pkg::imm_t imm);
        logic [W-1:0]  sext;
        logic [LW-1:0] zext;
        sext = {{(W-IMM_W){imm[IMM_W-1]}}, imm};
        zext = {{(LW-IMM_W){1'b0}}, imm};
        case (op)
            isa_pkg::add:    return a + b;
            isa_pkg::sub:    return a - b;
            isa_pkg::and_op: return a & b;
            isa_pkg::xor_op: return a ^ b;
            isa_pkg::addi:   return a + sext;
            isa_pkg::setlo:  return {{(W-LW){1'b0}}, zext};
            isa_pkg::sethi:  return {zext, {(W-LW){1'b0}}};
            default:         return '0;
        endcase
    endfunction

    function automatic rf_pkg::lane_mask_t lanes(input isa_pkg::opcode_e op);
        rf_pkg::lane_mask_t mask;
        mask = '1;
        case (op)
            isa_pkg::nop:   mask = '0;
            isa_pkg::setlo: mask = rf_pkg::lane_mask_t'(1);
            isa_pkg::sethi: mask = rf_pkg::lane_mask_t'(2);
            default:        mask = '1;
        endcase
        return mask;
    endfunction

    logic [W-1:0]       alu_0;
    logic [W-1:0]       alu_1;
    rf_pkg::lane_mask_t mask_0;
    rf_pkg::lane_mask_t mask_1;

    assign alu_0  = alu(ex_op_0, rd_dout_0, rd_dout_1, ex_imm_0);
    assign alu_1  = alu(ex_op_1, rd_dout_2, '0, ex_imm_1);
    assign mask_0 = ex_valid_0 ? lanes(ex_op_0) : '0;
    assign mask_1 = ex_valid_1 ? lanes(ex_op_1) : '0;

    // clearing zeroes a pair of entries per cycle on both ports.
    always_comb begin
        if (clearing) begin
            wr_addr_0   = clear_addr;
            wr_addr_1   = clear_addr + `RF_ADDR_W'(1);
            wr_enable_0 = '1;
            wr_enable_1 = '1;
            wr_din_0    = '0;
            wr_din_1    = '0;
        end else begin
            wr_addr_0   = ex_rd_0;
            wr_addr_1   = ex_rd_1;
            wr_enable_0 = mask_0;
            wr_enable_1 = mask_1;
            wr_din_0    = alu_0;
            wr_din_1    = alu_1;
        end
    end

    assign result_0       = alu_0;
    assign result_1       = alu_1;
    assign result_valid_0 = ex_valid_0 && (ex_op_0 != isa_pkg::nop) && !clearing;
    assign result_valid_1 = ex_valid_1 && (ex_op_1 != isa_pkg::nop) && !clearing;

    // every clear pass starts from entry zero.
    a_clear_from_zero: assert property (
        @(posedge clock) disable iff (!arst_n) (clearing && !$past(clearing)) |-> (clear_addr == '0)
    ) else $error("clear pass did not start at zero");

endmodule

/* hdl/issue_decode.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module issue_decode (
    input  logic                  clock,
    input  logic                  arst_n,
    input  isa_pkg::inst_u        inst_0,
    input  isa_pkg::inst_u        inst_1,
    input  logic                  inst_valid,
    input  logic                  ready,
    output logic [`RF_ADDR_W-1:0] rd_addr_0,
    output logic [`RF_ADDR_W-1:0] rd_addr_1,
    output logic [`RF_ADDR_W-1:0] rd_addr_2,
    output logic                  rd_enable_0,
    output logic                  rd_enable_1,
    output logic                  rd_enable_2,
    output isa_pkg::opcode_e      ex_op_0,
    output isa_pkg::opcode_e      ex_op_1,
    output logic [`RF_ADDR_W-1:0] ex_rd_0,
    output logic [`RF_ADDR_W-1:0] ex_rd_1,
    output isa_pkg::imm_t         ex_imm_0,
    output isa_pkg::imm_t         ex_imm_1,
    output logic                  ex_valid_0,
    output logic                  ex_valid_1
);

    function automatic logic is_rr_op(input isa_pkg::opcode_e op);
        return op inside {isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::xor_op};
    endfunction

    logic             accept;
    logic             slot0_rr;
    isa_pkg::opcode_e op_0;
    isa_pkg::opcode_e op_1;

    // pairs offered while not ready are dropped.
    assign accept   = inst_valid && ready;
    assign op_0     = inst_0.rr.op;
    assign op_1     = inst_1.ri.op;
    assign slot0_rr = is_rr_op(op_0);

    // slot 0 on ports 0 and 1, slot 1 on port 2.
    // rd and rs1 sit at the same bits in both formats.
    assign rd_addr_0   = inst_0.ri.rs1;
    assign rd_addr_1   = inst_0.rr.rs2;
    assign rd_addr_2   = inst_1.ri.rs1;
    assign rd_enable_0 = accept && (slot0_rr || (op_0 == isa_pkg::addi));
    assign rd_enable_1 = accept && slot0_rr;
    assign rd_enable_2 = accept && (op_1 == isa_pkg::addi);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid_0 <= 1'b0;
            ex_valid_1 <= 1'b0;
            ex_op_0    <= isa_pkg::nop;
            ex_op_1    <= isa_pkg::nop;
        end else begin
            ex_valid_0 <= accept;
            ex_valid_1 <= accept;
            if (accept) begin
                ex_op_0 <= op_0;
                ex_op_1 <= op_1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ex_rd_0  <= inst_0.ri.rd;
            ex_rd_1  <= inst_1.ri.rd;
            ex_imm_0 <= slot0_rr ? '0 : inst_0.ri.imm;
            ex_imm_1 <= inst_1.ri.imm;
        end
    end

    // slot 1 has a single read port, so only the ri format fits.
    a_slot1_ri_only: assert property (
        @(posedge clock) disable iff (!arst_n) ex_valid_1 |-> !is_rr_op(ex_op_1)
    ) else $error("rr opcode issued in slot 1");

endmodule

/* hdl/regfile_3r2w.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module regfile_3r2w (
    input  logic                   clock,

    input  logic [`RF_ADDR_W-1:0]  rd_addr_0,
    input  logic                   rd_enable_0,
    output logic [`RF_WIDTH-1:0]   rd_dout_0,

    input  logic [`RF_ADDR_W-1:0]  rd_addr_1,
    input  logic                   rd_enable_1,
    output logic [`RF_WIDTH-1:0]   rd_dout_1,

    input  logic [`RF_ADDR_W-1:0]  rd_addr_2,
    input  logic                   rd_enable_2,
    output logic [`RF_WIDTH-1:0]   rd_dout_2,

    input  logic [`RF_ADDR_W-1:0]  wr_addr_0,
    input  rf_pkg::lane_mask_t     wr_enable_0,
    input  logic [`RF_WIDTH-1:0]   wr_din_0,

    input  logic [`RF_ADDR_W-1:0]  wr_addr_1,
    input  rf_pkg::lane_mask_t     wr_enable_1,
    input  logic [`RF_WIDTH-1:0]   wr_din_1
);

    localparam int LW = `RF_LANE_W;

    logic [`RF_WIDTH-1:0] mem [`RF_DEPTH];

    // ========================================
    // write ports.
    // ========================================

    // port 1 is applied last so it wins on a shared address and lane.
    always_ff @(posedge clock) begin
        for (int l = 0; l < `RF_LANES; l++) begin
            if (wr_enable_0[l]) begin
                mem[wr_addr_0][l*LW +: LW] <= wr_din_0[l*LW +: LW];
            end
            if (wr_enable_1[l]) begin
                mem[wr_addr_1][l*LW +: LW] <= wr_din_1[l*LW +: LW];
            end
        end
    end

    // ========================================
    // read ports with forwarding.
    // ========================================

    // stored word patched lane by lane with writes landing on this edge.
    function automatic logic [`RF_WIDTH-1:0] fwd_word(input logic [`RF_ADDR_W-1:0] addr);
        logic [`RF_WIDTH-1:0] word;
        word = mem[addr];
        for (int l = 0; l < `RF_LANES; l++) begin
            if (wr_enable_1[l] && (wr_addr_1 == addr)) begin
                word[l*LW +: LW] = wr_din_1[l*LW +: LW];
            end else if (wr_enable_0[l] && (wr_addr_0 == addr)) begin
                word[l*LW +: LW] = wr_din_0[l*LW +: LW];
            end
        end
        return word;
    endfunction

    // a disabled port keeps its last value.
    always_ff @(posedge clock) begin
        if (rd_enable_0) begin
            rd_dout_0 <= fwd_word(rd_addr_0);
        end
        if (rd_enable_1) begin
            rd_dout_1 <= fwd_word(rd_addr_1);
        end
        if (rd_enable_2) begin
            rd_dout_2 <= fwd_word(rd_addr_2);
        end
    end

    // enables come from the execute stage and the clear sequencer.
    a_wr_enable_known: assert property (
        @(posedge clock) !$isunknown({wr_enable_0, wr_enable_1})
    ) else $error("write enable unknown");

endmodule

/* hdl/clear_sequencer.sv */
`timescale 1ns/1ps

module clear_sequencer (
    input  logic clock,
    input  logic arst_n,
    input  logic flush,
    input  logic last_pair,
    output logic clearing,
    output logic ready,
    output logic start
);

    rf_pkg::clr_state_e state;
    rf_pkg::clr_state_e state_nxt;

    // ========================================
    // state machine.
    // ========================================

    always_comb begin
        state_nxt = state;
        case (state)
            rf_pkg::s_clear: begin
                if (last_pair) begin
                    state_nxt = rf_pkg::s_run;
                end
            end
            rf_pkg::s_run: begin
                if (flush) begin
                    state_nxt = rf_pkg::s_clear;
                end
            end
            default: begin
                state_nxt = rf_pkg::s_clear;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= rf_pkg::s_clear;
        end else begin
            state <= state_nxt;
        end
    end

    // counter restarts on the edge that re-enters clearing.
    assign start    = flush && (state == rf_pkg::s_run);
    assign clearing = (state == rf_pkg::s_clear);
    assign ready    = (state == rf_pkg::s_run);

    a_ready_not_clearing: assert property (
        @(posedge clock) disable iff (!arst_n) !(ready && clearing)
    ) else $error("ready and clearing both high");

endmodule

/* hdl/clear_counter.sv */
`timescale 1ns/1ps
`include "rf_macros.svh"

module clear_counter (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  step,
    output logic [`RF_ADDR_W-1:0] clear_addr,
    output logic                  last_pair
);

    // two entries are zeroed per step.
    localparam logic [`RF_ADDR_W-1:0] STRIDE = `RF_ADDR_W'(2);
    localparam logic [`RF_ADDR_W-1:0] TOP    = `RF_ADDR_W'(`RF_DEPTH - 2);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            clear_addr <= '0;
        end else if (start) begin
            clear_addr <= '0;
        end else if (step) begin
            // wraps back to zero after the top pair.
            clear_addr <= clear_addr + STRIDE;
        end
    end

    assign last_pair = (clear_addr == TOP);

endmodule

/* hdl/rf_pkg.sv */
`include "rf_macros.svh"

package rf_pkg;

    // clear sequencer states.
    typedef enum logic [1:0] {
        s_clear = 2'd0,
        s_run   = 2'd1
    } clr_state_e;

    // one write enable per byte lane.
    typedef logic [`RF_LANES-1:0] lane_mask_t;

endpackage

/* hdl/isa_pkg.sv */
`include "rf_macros.svh"

package isa_pkg;

    // 4-bit opcode shared by both instruction formats.
    typedef enum logic [3:0] {
        nop    = 4'd0,
        add    = 4'd1,
        sub    = 4'd2,
        and_op = 4'd3,
        xor_op = 4'd4,
        addi   = 4'd5,
        setlo  = 4'd6,
        sethi  = 4'd7
    } opcode_e;

    typedef logic [5:0] imm_t;

    // register-register format.
    typedef struct packed {
        opcode_e              op;
        logic [`RF_ADDR_W-1:0] rd;
        logic [`RF_ADDR_W-1:0] rs1;
        logic [`RF_ADDR_W-1:0] rs2;
        logic [2:0]           pad;
    } inst_rr_s;

    // register-immediate format.
    typedef struct packed {
        opcode_e              op;
        logic [`RF_ADDR_W-1:0] rd;
        logic [`RF_ADDR_W-1:0] rs1;
        imm_t                 imm;
    } inst_ri_s;

    // one 16-bit word, seen through either format.
    typedef union packed {
        inst_rr_s rr;
        inst_ri_s ri;
    } inst_u;

endpackage

/* hdl/rf_macros.svh */
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// ========================================
// register file geometry.
// ========================================

// number of architectural registers.
`define RF_DEPTH 8

// register width in bits.
`define RF_WIDTH 16

// independent byte lanes for writes.
`define RF_LANES 2
`define RF_LANE_W 8

// enough bits to index RF_DEPTH entries.
`define RF_ADDR_W 3

`endif
